/* barrier_node.sv */
`default_nettype none

module barrier_node
  import barrier_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  sync_hs_t child_i [2],  // Child links, req is what counts here
  output sync_hs_t child_o [2],  // Ack back down, req is the joined request
  output logic     parent_req_o,
  input  logic     parent_ack_i
);

  barrier_state_e state_q;
  barrier_state_e state_d;
  logic           all_req;   // Both children waiting
  logic           none_req;  // Both children gone
  logic           child_ack;

  assign all_req  = child_i[0].req & child_i[1].req;
  assign none_req = ~child_i[0].req & ~child_i[1].req;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      BAR_IDLE: begin
        if (all_req) state_d = BAR_JOINED;
      end
      BAR_JOINED: begin
        if (parent_ack_i) state_d = BAR_RELEASED;  // Root has seen everyone
      end
      BAR_RELEASED: begin
        if (none_req) state_d = BAR_DRAINING;
      end
      BAR_DRAINING: begin
        if (!parent_ack_i) state_d = BAR_IDLE;
      end
      default: state_d = BAR_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= BAR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Outputs decode the state register, so one stage each way
  assign parent_req_o = (state_q == BAR_JOINED) || (state_q == BAR_RELEASED);
  assign child_ack    = (state_q == BAR_RELEASED) || (state_q == BAR_DRAINING);

  for (genvar k = 0; k < 2; k++) begin : gen_child
    assign child_o[k].req = parent_req_o;  // Joined request, for monitors
    assign child_o[k].ack = child_ack;     // Both children released together
  end

endmodule

`default_nettype wire

/* barrier_pkg.sv */
`default_nettype none

package barrier_pkg;

  // Barrier node FSM
  typedef enum logic [1:0] {
    BAR_IDLE,      // Waiting for both children
    BAR_JOINED,    // Parent request up, waiting for parent ack
    BAR_RELEASED,  // Children acked, waiting for them to drop
    BAR_DRAINING   // Parent request down, waiting for parent ack to fall
  } barrier_state_e;

  // One four-phase sync link
  typedef struct packed {
    logic req;
    logic ack;
  } sync_hs_t;

endpackage

`default_nettype wire

/* barrier_tree.sv */
`default_nettype none

`include "svc_defines.svh"

module barrier_tree
  import svc_pkg::*;
  import barrier_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic [`SVC_N_TILES-1:0] sync_req_i,
  output logic [`SVC_N_TILES-1:0] sync_ack_o
);

  sync_hs_t   leaf_in  [2][2];  // Tile links into each leaf
  sync_hs_t   leaf_out [2][2];
  sync_hs_t   top_in   [2];     // Leaf links into the top node
  sync_hs_t   top_out  [2];
  logic [1:0] leaf_req;         // Leaf parent requests
  logic       top_req;          // Root request
  logic       root_ack_q;       // Root responder

  // Leaf level, tiles 0/1 and 2/3
  for (genvar l = 0; l < 2; l++) begin : gen_leaf
    for (genvar k = 0; k < 2; k++) begin : gen_tile
      localparam tile_id_t TILE = tile_id_t'(2 * l + k);

      assign leaf_in[l][k].req = sync_req_i[TILE];
      assign leaf_in[l][k].ack = sync_ack_o[TILE];
      assign sync_ack_o[TILE]  = leaf_out[l][k].ack;
    end

    barrier_node i_leaf (
      .clk          ( clk            ),
      .rst_n_i      ( rst_n_i        ),
      .child_i      ( leaf_in[l]     ),
      .child_o      ( leaf_out[l]    ),
      .parent_req_o ( leaf_req[l]    ),
      .parent_ack_i ( top_out[l].ack )
    );

    assign top_in[l].req = leaf_req[l];
    assign top_in[l].ack = top_out[l].ack;
  end

  // Top level joins the two leaves
  barrier_node i_top (
    .clk          ( clk        ),
    .rst_n_i      ( rst_n_i    ),
    .child_i      ( top_in     ),
    .child_o      ( top_out    ),
    .parent_req_o ( top_req    ),
    .parent_ack_i ( root_ack_q )
  );

  // Root answers one cycle after each edge of the top request
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      root_ack_q <= 1'b0;
    end else begin
      root_ack_q <= top_req;
    end
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
svc_pkg.sv
barrier_pkg.sv
barrier_node.sv
barrier_tree.sv
tile_port.sv
console_line_buf.sv
console_arbiter.sv
mesh_svc_hub.sv
mesh_svc_assertions.sv
tb_mesh_svc_hub.sv

/* console_arbiter.sv */
`default_nettype none

`include "svc_defines.svh"

module console_arbiter
  import svc_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  logic      [`SVC_N_TILES-1:0]   line_ready_i,
  input  char_t     [`SVC_N_TILES-1:0]   head_i,
  input  logic      [`SVC_N_TILES-1:0]   head_last_i,
  output logic      [`SVC_N_TILES-1:0]   pop_o,
  output con_char_t                      con_o,      // Stable while con_req_o
  output logic                           con_req_o,
  input  logic                           con_ack_i
);

  typedef enum logic [1:0] {
    ARB_IDLE,  // No line in progress
    ARB_SEND,  // Character offered, waiting for ack
    ARB_WAIT   // Ack seen, waiting for it to fall
  } arb_state_e;

  arb_state_e state_q;
  tile_id_t   cur_q;     // Tile being served
  tile_id_t   rr_q;      // Tile served last
  tile_id_t   pick;      // Next tile in round-robin order
  logic       pick_vld;
  tile_id_t   src;       // Tile whose head gets loaded
  logic       load;      // Offer a new character

  // Round robin, first ready tile after rr_q wins
  always_comb begin
    int idx;
    pick     = rr_q;
    pick_vld = 1'b0;
    for (int k = `SVC_N_TILES; k >= 1; k--) begin
      idx = (int'(rr_q) + k) % `SVC_N_TILES;
      if (line_ready_i[idx]) begin
        pick     = tile_id_t'(idx);
        pick_vld = 1'b1;
      end
    end
  end

  // Pop each character once its ack arrives
  always_comb begin
    pop_o = '0;
    if ((state_q == ARB_SEND) && con_ack_i) begin
      pop_o[cur_q] = 1'b1;
    end
  end

  // New line from the picked tile, else the next character of the current one
  assign load = ((state_q == ARB_IDLE) && pick_vld) ||
                ((state_q == ARB_WAIT) && !con_ack_i && !con_o.last);
  assign src  = (state_q == ARB_IDLE) ? pick : cur_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= ARB_IDLE;
      cur_q     <= '0;
      rr_q      <= tile_id_t'(`SVC_N_TILES - 1);  // Tile 0 goes first
      con_req_o <= 1'b0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (pick_vld) begin
            cur_q     <= pick;
            con_req_o <= 1'b1;
            state_q   <= ARB_SEND;
          end
        end
        ARB_SEND: begin
          if (con_ack_i) begin
            con_req_o <= 1'b0;
            state_q   <= ARB_WAIT;
          end
        end
        ARB_WAIT: begin
          if (!con_ack_i) begin
            if (con_o.last) begin
              rr_q    <= cur_q;  // Line done, release the tile
              state_q <= ARB_IDLE;
            end else begin
              con_req_o <= 1'b1;
              state_q   <= ARB_SEND;
            end
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  // Output payload
  always_ff @(posedge clk) begin
    if (load) begin
      con_o.tile <= src;
      con_o.last <= head_last_i[src];
      con_o.ch   <= head_i[src];
    end
  end

endmodule

`default_nettype wire

/* console_line_buf.sv */
`default_nettype none

`include "svc_defines.svh"

module console_line_buf
  import svc_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  char_t push_char_i,
  output logic  push_ready_o,  // Low from line ready until drained
  output logic  line_ready_o,
  input  logic  pop_i,         // Head consumed
  output char_t head_o,
  output logic  head_last_o    // Head is the final character of the line
);

  localparam int unsigned PTR_W   = $clog2(`SVC_LINE_MAX);
  localparam char_t       NEWLINE = 8'h0A;

  typedef logic [PTR_W:0] cnt_t;  // Room for a full buffer count

  char_t mem_q [`SVC_LINE_MAX];  // Line storage
  cnt_t  wr_cnt_q;               // Characters held
  cnt_t  rd_ptr_q;               // Next character out
  logic  ready_q;                // Line complete, draining
  logic  line_end;               // Current push closes the line

  // Newline or last free slot ends the line
  assign line_end = (push_char_i == NEWLINE) ||
                    (wr_cnt_q == cnt_t'(`SVC_LINE_MAX - 1));

  assign push_ready_o = ~ready_q;
  assign line_ready_o = ready_q;
  assign head_o       = mem_q[rd_ptr_q[PTR_W-1:0]];
  assign head_last_o  = (rd_ptr_q == wr_cnt_q - cnt_t'(1));

  // Storage write
  always_ff @(posedge clk) begin
    if (push_i && !ready_q) begin
      mem_q[wr_cnt_q[PTR_W-1:0]] <= push_char_i;
    end
  end

  // Fill, then drain
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_cnt_q <= '0;
      rd_ptr_q <= '0;
      ready_q  <= 1'b0;
    end else if (!ready_q) begin
      if (push_i) begin
        wr_cnt_q <= wr_cnt_q + cnt_t'(1);
        ready_q  <= line_end;
      end
    end else if (pop_i) begin
      if (head_last_o) begin
        // Line gone, buffer empty again
        wr_cnt_q <= '0;
        rd_ptr_q <= '0;
        ready_q  <= 1'b0;
      end else begin
        rd_ptr_q <= rd_ptr_q + cnt_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* mesh_svc_assertions.sv */
`default_nettype none

`include "svc_defines.svh"

module mesh_svc_assertions
  import svc_pkg::*;
(
  input logic                    clk,
  input logic                    rst_n_i,
  input logic [`SVC_N_TILES-1:0] wr_req_i,
  input logic [`SVC_N_TILES-1:0] wr_ack_o,
  input logic [`SVC_N_TILES-1:0] sync_req_i,
  input logic [`SVC_N_TILES-1:0] sync_ack_o,
  input con_char_t               con_o,
  input logic                    con_req_o
);

  int unsigned fail_cnt = 0;  // Read by the testbench

  // Payload frozen while offered
  a_con_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    con_req_o && $past(con_req_o) |-> $stable(con_o))
    else begin
      fail_cnt++;
      $error("con_o changed while con_req_o was high");
    end

  for (genvar t = 0; t < `SVC_N_TILES; t++) begin : gen_tile
    // Release only once every tile has arrived
    a_sync_all: assert property (@(posedge clk) disable iff (!rst_n_i)
      $rose(sync_ack_o[t]) |-> $past(&sync_req_i))
      else begin
        fail_cnt++;
        $error("sync ack of tile %0d rose without all requests", t);
      end

    a_wr_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
      $rose(wr_ack_o[t]) |-> $past(wr_req_i[t]))  // Ack needs a pending write
      else begin
        fail_cnt++;
        $error("write ack of tile %0d rose without a request", t);
      end
  end

endmodule

bind mesh_svc_hub mesh_svc_assertions i_hub_assert (
  .clk        ( clk        ),
  .rst_n_i    ( rst_n_i    ),
  .wr_req_i   ( wr_req_i   ),
  .wr_ack_o   ( wr_ack_o   ),
  .sync_req_i ( sync_req_i ),
  .sync_ack_o ( sync_ack_o ),
  .con_o      ( con_o      ),
  .con_req_o  ( con_req_o  )
);

`default_nettype wire

/* mesh_svc_hub.sv */
`default_nettype none

`include "svc_defines.svh"

module mesh_svc_hub
  import svc_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst_n_i,
  // Tile writes
  input  logic         [`SVC_N_TILES-1:0]   wr_req_i,
  input  svc_wr_t      [`SVC_N_TILES-1:0]   wr_i,
  output logic         [`SVC_N_TILES-1:0]   wr_ack_o,
  // Barrier
  input  logic         [`SVC_N_TILES-1:0]   sync_req_i,
  output logic         [`SVC_N_TILES-1:0]   sync_ack_o,
  // Status
  output tile_status_t [`SVC_N_TILES-1:0]   status_o,
  // Console
  output con_char_t                         con_o,
  output logic                              con_req_o,
  input  logic                              con_ack_i
);

  logic  [`SVC_N_TILES-1:0] push;        // Tile port into line buffer
  char_t [`SVC_N_TILES-1:0] push_char;
  logic  [`SVC_N_TILES-1:0] push_ready;
  logic  [`SVC_N_TILES-1:0] line_ready;  // Line buffer to arbiter
  logic  [`SVC_N_TILES-1:0] pop;
  char_t [`SVC_N_TILES-1:0] head;
  logic  [`SVC_N_TILES-1:0] head_last;

  for (genvar t = 0; t < `SVC_N_TILES; t++) begin : gen_tile
    tile_port i_tile_port (
      .clk          ( clk           ),
      .rst_n_i      ( rst_n_i       ),
      .wr_req_i     ( wr_req_i[t]   ),
      .wr_i         ( wr_i[t]       ),
      .wr_ack_o     ( wr_ack_o[t]   ),
      .push_o       ( push[t]       ),
      .push_char_o  ( push_char[t]  ),
      .push_ready_i ( push_ready[t] ),
      .status_o     ( status_o[t]   )
    );

    console_line_buf i_line_buf (
      .clk          ( clk           ),
      .rst_n_i      ( rst_n_i       ),
      .push_i       ( push[t]       ),
      .push_char_i  ( push_char[t]  ),
      .push_ready_o ( push_ready[t] ),
      .line_ready_o ( line_ready[t] ),
      .pop_i        ( pop[t]        ),
      .head_o       ( head[t]       ),
      .head_last_o  ( head_last[t]  )
    );
  end

  console_arbiter i_con_arb (
    .clk          ( clk        ),
    .rst_n_i      ( rst_n_i    ),
    .line_ready_i ( line_ready ),
    .head_i       ( head       ),
    .head_last_i  ( head_last  ),
    .pop_o        ( pop        ),
    .con_o        ( con_o      ),
    .con_req_o    ( con_req_o  ),
    .con_ack_i    ( con_ack_i  )
  );

  barrier_tree i_barrier (
    .clk        ( clk        ),
    .rst_n_i    ( rst_n_i    ),
    .sync_req_i ( sync_req_i ),
    .sync_ack_o ( sync_ack_o )
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_mesh_svc_hub -Mdir obj_dir

./obj_dir/Vtb_mesh_svc_hub +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation reported errors"
  exit 1
fi
echo "Simulation finished without errors"

/* svc_defines.svh */
`ifndef SVC_DEFINES_SVH
`define SVC_DEFINES_SVH

// Hub geometry
`define SVC_N_TILES    4   // Compute tiles served by the hub
`define SVC_LINE_MAX   16  // Characters per console line buffer

// Tile register map
`define SVC_OFF_STDIO  0   // Console character
`define SVC_OFF_STDERR 1   // Error count
`define SVC_OFF_EOC    2   // Exit code, marks tile done

// Anything else in the 4-bit offset space is acked and dropped

`endif

/* svc_pkg.sv */
`default_nettype none

`include "svc_defines.svh"

package svc_pkg;

  // Vector types with a meaning of their own
  typedef logic [$clog2(`SVC_N_TILES)-1:0] tile_id_t;
  typedef logic [7:0]                      char_t;
  typedef logic [3:0]                      svc_off_t;
  typedef logic [7:0]                      exit_code_t;
  typedef logic [7:0]                      err_count_t;

  // One tile write, held stable under wr_req
  typedef struct packed {
    svc_off_t off;   // Register offset
    char_t    data;  // Payload byte
  } svc_wr_t;

  // One character on the console port
  typedef struct packed {
    tile_id_t tile;  // Source tile
    logic     last;  // Final character of the line
    char_t    ch;
  } con_char_t;

  // Per-tile status as seen from outside
  typedef struct packed {
    logic       done;       // Exit register written
    exit_code_t exit_code;
    err_count_t err_count;
  } tile_status_t;

endpackage

`default_nettype wire

/* tb_mesh_svc_hub.sv */
`default_nettype none

`include "svc_defines.svh"

module tb_mesh_svc_hub
  import svc_pkg::*;
();

  localparam int    TIMEOUT = 2000;   // Cycles allowed per wait
  localparam char_t NEWLINE = 8'h0A;

  typedef char_t char_q_t[$];

  logic                              clk;
  logic                              rst_n;
  logic         [`SVC_N_TILES-1:0]   wr_req;
  svc_wr_t      [`SVC_N_TILES-1:0]   wr_data;
  logic         [`SVC_N_TILES-1:0]   wr_ack;
  logic         [`SVC_N_TILES-1:0]   sync_req;
  logic         [`SVC_N_TILES-1:0]   sync_ack;
  tile_status_t [`SVC_N_TILES-1:0]   status;
  con_char_t                         con;
  logic                              con_req;
  logic                              con_ack;

  integer       seed;                     // $random state
  char_t        send_q [`SVC_N_TILES][$]; // Bytes still to write per tile
  char_t        pend_q [`SVC_N_TILES][$]; // Open line in the model
  con_char_t    exp_q  [`SVC_N_TILES][$]; // Expected console output
  tile_status_t exp_st;

  mesh_svc_hub DUT (
    .clk        ( clk      ),
    .rst_n_i    ( rst_n    ),
    .wr_req_i   ( wr_req   ),
    .wr_i       ( wr_data  ),
    .wr_ack_o   ( wr_ack   ),
    .sync_req_i ( sync_req ),
    .sync_ack_o ( sync_ack ),
    .status_o   ( status   ),
    .con_o      ( con      ),
    .con_req_o  ( con_req  ),
    .con_ack_i  ( con_ack  )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("Fail at time %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  // One cycle of a bounded wait
  task automatic tick_with_timeout(inout int n, input string what);
    @(negedge clk);
    n++;
    if (n > TIMEOUT) report_problem($sformatf("Timeout waiting for %s", what));
  endtask

  task automatic check_con(input con_char_t got, input con_char_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("console tile %0d char 0x%02h last %0b, expected %0d 0x%02h %0b",
                                got.tile, got.ch, got.last, exp.tile, exp.ch, exp.last));
    end
  endtask

  task automatic check_status(input int t, input tile_status_t got, input tile_status_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("tile %0d status done %0b exit 0x%02h err 0x%02h, expected %0b %02h %02h",
                                t, got.done, got.exit_code, got.err_count,
                                exp.done, exp.exit_code, exp.err_count));
    end
  endtask

  task automatic check_flags(input string what, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  // Model: newline or a full buffer closes a line, last flag on its final char
  function automatic void build_expected(input int t, input char_q_t text);
    con_char_t c;
    foreach (text[i]) begin
      pend_q[t].push_back(text[i]);
      if (text[i] == NEWLINE || pend_q[t].size() == `SVC_LINE_MAX) begin
        for (int j = 0; j < pend_q[t].size(); j++) begin
          c.tile = tile_id_t'(t);
          c.last = (j == pend_q[t].size() - 1);
          c.ch   = pend_q[t][j];
          exp_q[t].push_back(c);
        end
        pend_q[t].delete();  // Partial line stays open otherwise
      end
    end
  endfunction

  function automatic int expected_left();
    int n;
    n = 0;
    for (int t = 0; t < `SVC_N_TILES; t++) n += exp_q[t].size();
    return n;
  endfunction

  task automatic queue_chars(input int t, input char_q_t text);
    foreach (text[i]) send_q[t].push_back(text[i]);
    build_expected(t, text);
  endtask

  task automatic queue_text(input int t, input string s);
    char_q_t text;
    for (int i = 0; i < s.len(); i++) text.push_back(char_t'(s[i]));
    queue_chars(t, text);
  endtask

  task automatic queue_random_line(input int t, input int len);
    char_q_t text;
    for (int i = 0; i < len; i++) begin
      text.push_back(char_t'(8'h61 + $unsigned($random(seed)) % 26));  // a to z
    end
    text.push_back(NEWLINE);
    queue_chars(t, text);
  endtask

  // Four-phase tile write
  task automatic write_reg(input int t, input svc_off_t off, input char_t data);
    int n;
    @(negedge clk);
    wr_data[t].off  = off;
    wr_data[t].data = data;
    wr_req[t]       = 1'b1;
    n = 0;
    while (!wr_ack[t]) tick_with_timeout(n, "write ack to rise");
    wr_req[t] = 1'b0;
    n = 0;
    while (wr_ack[t]) tick_with_timeout(n, "write ack to fall");
  endtask

  task automatic send_text(input int t);
    while (send_q[t].size() > 0) write_reg(t, svc_off_t'(`SVC_OFF_STDIO), send_q[t].pop_front());
  endtask

  task automatic set_sync(input int t, input logic v);
    @(negedge clk);
    sync_req[t] = v;
  endtask

  // Console sink and compare, runs until the model has nothing left
  task automatic drain_console();
    con_char_t got;
    tile_id_t  cur;
    logic      in_line;
    int        n;
    int        delay;
    in_line = 1'b0;
    cur     = '0;
    while (expected_left() > 0) begin
      n = 0;
      while (!con_req) tick_with_timeout(n, "a console character");
      got = con;
      if (in_line && got.tile != cur) begin
        report_mismatch($sformatf("tile %0d broke into the line of tile %0d", got.tile, cur));
      end
      if (exp_q[got.tile].size() == 0) begin
        report_mismatch($sformatf("unexpected character 0x%02h from tile %0d", got.ch, got.tile));
      end
      check_con(got, exp_q[got.tile].pop_front());
      cur     = got.tile;
      in_line = !got.last;
      delay   = $unsigned($random(seed)) % 4;  // Slow sink
      repeat (delay) @(negedge clk);
      con_ack = 1'b1;
      n = 0;
      while (con_req) tick_with_timeout(n, "console req to fall");
      con_ack = 1'b0;
    end
  endtask

  task automatic run_console();
    fork
      send_text(0);
      send_text(1);
      send_text(2);
      send_text(3);
      drain_console();
    join
  endtask

  // Bound assertion failures end the run too
  always @(negedge clk) begin
    if (DUT.i_hub_assert.fail_cnt != 0) report_problem("A bound handshake assertion failed");
  end

  initial begin
    int n;
    seed     = 32'h1659_1adc;
    rst_n    = 1'b0;
    wr_req   = '0;
    wr_data  = '0;
    sync_req = '0;
    con_ack  = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Reset values
    check_flags("wr_ack_o", wr_ack, 4'h0);
    check_flags("sync_ack_o", sync_ack, 4'h0);
    check_flags("con_req_o", {3'b000, con_req}, 4'h0);
    for (int t = 0; t < `SVC_N_TILES; t++) check_status(t, status[t], '0);

    // One tile, one line
    queue_text(0, "hi mesh\n");
    run_console();

    // All tiles at once, three lines each
    for (int t = 0; t < `SVC_N_TILES; t++) begin
      for (int l = 0; l < 3; l++) queue_random_line(t, 1 + $unsigned($random(seed)) % 20);
    end
    run_console();

    // Long line splits at 16, the rest waits for the newline
    queue_text(1, "abcdefghijklmnopqrst");
    run_console();
    repeat (40) begin
      @(negedge clk);
      check_flags("con_req_o on open line", {3'b000, con_req}, 4'h0);
    end
    queue_text(1, "\n");
    run_console();

    // Barrier holds with three tiles
    for (int t = 0; t < 3; t++) set_sync(t, 1'b1);
    repeat (50) begin
      @(negedge clk);
      check_flags("sync_ack_o with three tiles", sync_ack, 4'h0);
    end
    set_sync(3, 1'b1);
    n = 0;
    while (sync_ack == '0) tick_with_timeout(n, "sync ack to rise");
    check_flags("sync_ack_o after release", sync_ack, 4'hF);
    for (int t = 0; t < 3; t++) set_sync(t, 1'b0);
    repeat (20) begin
      @(negedge clk);
      check_flags("sync_ack_o with tile 3 still up", sync_ack, 4'hF);
    end
    set_sync(3, 1'b0);
    n = 0;
    while (sync_ack != '0) tick_with_timeout(n, "sync ack to fall");

    // Error and exit registers, unknown offset ignored
    exp_st           = '0;
    exp_st.err_count = 8'h05;
    write_reg(2, svc_off_t'(`SVC_OFF_STDERR), 8'h05);
    check_status(2, status[2], exp_st);
    exp_st.exit_code = 8'h2A;
    exp_st.done      = 1'b1;
    write_reg(2, svc_off_t'(`SVC_OFF_EOC), 8'h2A);
    check_status(2, status[2], exp_st);
    write_reg(3, svc_off_t'(7), 8'h99);
    check_status(3, status[3], '0);
    check_status(0, status[0], '0);
    check_status(1, status[1], '0);

    if (DUT.i_hub_assert.fail_cnt == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      report_problem("A bound handshake assertion failed");
    end
  end

endmodule

`default_nettype wire

/* tile_port.sv */
`default_nettype none

`include "svc_defines.svh"

module tile_port
  import svc_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         wr_req_i,
  input  svc_wr_t      wr_i,          // Stable while wr_req_i is high
  output logic         wr_ack_o,
  output logic         push_o,        // Console byte into the line buffer
  output char_t        push_char_o,
  input  logic         push_ready_i,  // Line buffer can take a byte
  output tile_status_t status_o
);

  logic is_stdio;
  logic is_stderr;
  logic is_eoc;
  logic accept;  // Write taken this cycle

  // Offset decode
  assign is_stdio  = (wr_i.off == svc_off_t'(`SVC_OFF_STDIO));
  assign is_stderr = (wr_i.off == svc_off_t'(`SVC_OFF_STDERR));
  assign is_eoc    = (wr_i.off == svc_off_t'(`SVC_OFF_EOC));

  // Console write stalls until the buffer is free again
  assign accept = wr_req_i & ~wr_ack_o & (~is_stdio | push_ready_i);

  assign push_o      = accept & is_stdio;
  assign push_char_o = wr_i.data;

  // Four-phase ack, falls the cycle after req drops
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ack_o <= 1'b0;
    end else if (accept) begin
      wr_ack_o <= 1'b1;
    end else if (!wr_req_i) begin
      wr_ack_o <= 1'b0;
    end
  end

  // Error and exit registers, unknown offsets fall through
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      status_o <= '0;
    end else if (accept) begin
      if (is_stderr) begin
        status_o.err_count <= err_count_t'(wr_i.data);
      end
      if (is_eoc) begin
        status_o.exit_code <= exit_code_t'(wr_i.data);
        status_o.done      <= 1'b1;  // Sticky until reset
      end
    end
  end

endmodule

`default_nettype wire
